// File: project.f
source/xaui_pkg.sv
source/link_pkg.sv
source/word_stream_if.sv
source/link_ctrl.sv
source/tx_credit_buffer.sv
source/lane_encoder.sv
source/lane_decoder.sv
source/xaui_link_top.sv
verification/xaui_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the xaui link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
  --top-module xaui_link_tb --Mdir obj_dir -o xaui_link_sim

out=$(./obj_dir/xaui_link_sim)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1

// File: verification/xaui_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module xaui_link_tb;

  localparam int CLK_PERIOD      = 4;
  localparam int WATCHDOG_CYCLES = 2000; // all six tests take a few hundred cycles
  localparam int DEPTH           = link_pkg::TX_DEPTH;
  localparam logic [63:0] IDLE_EXP = {8{xaui_pkg::IDLE_CHAR}};

  logic                   mgt_clk;
  logic                   rst_n_i;
  logic                   tx_valid_i;
  xaui_pkg::mgt_data_t    tx_data_i;
  logic                   tx_last_i;
  logic                   tx_credit_o;
  logic                   rx_credit_i;
  logic                   rx_valid_o;
  xaui_pkg::mgt_data_t    rx_data_o;
  logic                   rx_last_o;
  logic                   link_up_o;
  xaui_pkg::mgt_data_t    mgt_txdata_o;
  xaui_pkg::mgt_charisk_t mgt_txcharisk_o;
  xaui_pkg::mgt_data_t    mgt_rxdata_i;
  xaui_pkg::mgt_charisk_t mgt_rxcharisk_i;
  xaui_pkg::mgt_charisk_t mgt_codevalid_i;
  xaui_pkg::lane_mask_t   mgt_syncok_i;
  xaui_pkg::lane_mask_t   mgt_rxlock_i;
  logic                   mgt_tx_reset_o;
  logic                   mgt_rx_reset_o;
  logic                   mgt_enable_align_o;
  link_pkg::count_t       err_count_o;
  link_pkg::count_t       drop_count_o;

  logic        corrupt_k;
  int          errors = 0;
  int          checks = 0;
  int          words_sent = 0;
  int          credit_pulses = 0;
  int          rx_taken = 0;
  logic [63:0] exp_data_q[$];
  logic        exp_last_q[$];
  logic [63:0] got_data_q[$];
  logic        got_last_q[$];

  xaui_link_top dut (
    .rst_n_i           (rst_n_i),
    .mgt_clk           (mgt_clk),
    .tx_valid_i        (tx_valid_i),
    .tx_data_i         (tx_data_i),
    .tx_last_i         (tx_last_i),
    .tx_credit_o       (tx_credit_o),
    .rx_credit_i       (rx_credit_i),
    .rx_valid_o        (rx_valid_o),
    .rx_data_o         (rx_data_o),
    .rx_last_o         (rx_last_o),
    .link_up_o         (link_up_o),
    .mgt_txdata_o      (mgt_txdata_o),
    .mgt_txcharisk_o   (mgt_txcharisk_o),
    .mgt_rxdata_i      (mgt_rxdata_i),
    .mgt_rxcharisk_i   (mgt_rxcharisk_i),
    .mgt_codevalid_i   (mgt_codevalid_i),
    .mgt_syncok_i      (mgt_syncok_i),
    .mgt_rxlock_i      (mgt_rxlock_i),
    .mgt_tx_reset_o    (mgt_tx_reset_o),
    .mgt_rx_reset_o    (mgt_rx_reset_o),
    .mgt_enable_align_o(mgt_enable_align_o),
    .err_count_o       (err_count_o),
    .drop_count_o      (drop_count_o)
  );

  // loopback with the upper flags flipped when corrupting
  assign mgt_rxdata_i    = mgt_txdata_o;
  assign mgt_rxcharisk_i = corrupt_k ? (mgt_txcharisk_o ^ 8'hF0) : mgt_txcharisk_o;

  initial begin
    mgt_clk = 1'b0;
    forever #(CLK_PERIOD / 2) mgt_clk = ~mgt_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, a test never finished", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  // sampled on the falling edge away from the register updates
  always @(negedge mgt_clk) begin
    if (rst_n_i) begin
      if (tx_credit_o) begin
        credit_pulses++;
      end
      if (rx_valid_o) begin
        got_data_q.push_back(rx_data_o);
        got_last_q.push_back(rx_last_o);
      end
    end
  end

  task automatic next_cycle();
    @(posedge mgt_clk);
    #1;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic end_test(input int num, input string name, input int err_start);
    $display("test %0d %s: %s", num, name, (errors == err_start) ? "ok" : "FAILED");
  endtask

  task automatic wait_link(input logic up, input int limit, output int cycles);
    cycles = 0;
    while (link_up_o !== up && cycles < limit) begin
      next_cycle();
      cycles++;
    end
    check_true(link_up_o === up,
               $sformatf("link_up_o did not reach %0d within %0d cycles", up, limit));
  endtask

  task automatic wait_tx_drained(input int limit);
    int waited;
    waited = 0;
    while (credit_pulses != words_sent && waited < limit) begin
      next_cycle();
      waited++;
    end
    check_true(credit_pulses == words_sent, "transmit credits were not all returned");
  endtask

  task automatic wait_rx_words(input int count, input int limit);
    int waited;
    waited = 0;
    while (got_data_q.size() - rx_taken < count && waited < limit) begin
      next_cycle();
      waited++;
    end
  endtask

  task automatic grant_rx(input int n);
    repeat (n) begin
      rx_credit_i = 1'b1;
      next_cycle();
    end
    rx_credit_i = 1'b0;
  endtask

  task automatic send_frame(input int len, input bit expect_back);
    xaui_pkg::mgt_data_t word;
    int i;
    for (i = 0; i < len; i++) begin
      word       = {$urandom, $urandom};
      tx_valid_i = 1'b1;
      tx_data_i  = word;
      tx_last_i  = (i == len - 1);
      words_sent++;
      if (expect_back) begin
        exp_data_q.push_back(word);
        exp_last_q.push_back(i == len - 1); // last only on the final word
      end
      next_cycle();
    end
    tx_valid_i = 1'b0;
    tx_last_i  = 1'b0;
  endtask

  task automatic compare_frame();
    int n;
    int avail;
    avail = got_data_q.size() - rx_taken;
    check_val("rx word count", 64'(avail), 64'(exp_data_q.size()));
    n = 0;
    while (n < avail && n < exp_data_q.size()) begin
      check_val($sformatf("rx_data_o[%0d]", n), got_data_q[rx_taken + n], exp_data_q[n]);
      check_val($sformatf("rx_last_o[%0d]", n), 64'(got_last_q[rx_taken + n]),
                64'(exp_last_q[n]));
      n++;
    end
    rx_taken = got_data_q.size();
    exp_data_q.delete();
    exp_last_q.delete();
  endtask

  task automatic test_reset();
    int e0;
    int cycles;
    e0 = errors;
    check_val("link_up_o", 64'(link_up_o), 64'd0);
    check_val("tx_credit_o", 64'(tx_credit_o), 64'd0);
    check_val("rx_valid_o", 64'(rx_valid_o), 64'd0);
    check_val("mgt_txdata_o", mgt_txdata_o, IDLE_EXP);
    check_val("mgt_txcharisk_o", 64'(mgt_txcharisk_o), 64'hFF);
    cycles = 0;
    while (!mgt_enable_align_o && cycles < 50) begin
      check_true(mgt_tx_reset_o && mgt_rx_reset_o,
                 "transceiver resets dropped before alignment");
      next_cycle();
      cycles++;
    end
    check_val("reset hold cycles", 64'(cycles), 64'(link_pkg::RESET_CYCLES));
    check_val("mgt_tx_reset_o", 64'(mgt_tx_reset_o), 64'd0);
    check_val("mgt_rx_reset_o", 64'(mgt_rx_reset_o), 64'd0);
    end_test(1, "reset and bring-up", e0);
  endtask

  task automatic test_link();
    int e0;
    int cycles;
    e0 = errors;
    mgt_syncok_i = '1;
    mgt_rxlock_i = '1;
    wait_link(1'b1, 20, cycles);
    check_val("link up latency", 64'(cycles), 64'd1);
    mgt_syncok_i[2] = 1'b0; // lane 2 loses sync
    next_cycle();
    check_val("link_up_o", 64'(link_up_o), 64'd0);
    check_val("mgt_enable_align_o", 64'(mgt_enable_align_o), 64'd1);
    next_cycle();
    check_val("mgt_txdata_o", mgt_txdata_o, IDLE_EXP);
    check_val("mgt_txcharisk_o", 64'(mgt_txcharisk_o), 64'hFF);
    mgt_syncok_i = '1;
    wait_link(1'b1, 20, cycles);
    end_test(2, "link up and down", e0);
  endtask

  task automatic test_frame();
    int e0;
    e0 = errors;
    grant_rx(6);
    send_frame(6, 1'b1);
    wait_rx_words(6, 100);
    compare_frame();
    wait_tx_drained(50);
    end_test(3, "frame loopback", e0);
  endtask

  task automatic test_tx_credit();
    int e0;
    int base;
    int cycles;
    e0   = errors;
    base = credit_pulses;
    mgt_rxlock_i[0] = 1'b0;
    wait_link(1'b0, 10, cycles);
    send_frame(DEPTH, 1'b1);
    run_cycles(10);
    check_val("tx credits while down", 64'(credit_pulses - base), 64'd0);
    // buffer is full but the line stays idle
    check_val("mgt_txdata_o", mgt_txdata_o, IDLE_EXP);
    check_val("mgt_txcharisk_o", 64'(mgt_txcharisk_o), 64'hFF);
    grant_rx(DEPTH);
    mgt_rxlock_i = '1;
    wait_link(1'b1, 20, cycles);
    wait_tx_drained(100);
    run_cycles(10);
    check_val("tx credits after up", 64'(credit_pulses - base), 64'(DEPTH));
    wait_rx_words(DEPTH, 100);
    compare_frame();
    end_test(4, "transmit credits", e0);
  endtask

  task automatic test_drop();
    int e0;
    int base;
    int waited;
    e0   = errors;
    base = int'(drop_count_o);
    send_frame(5, 1'b0); // no receive credits left
    waited = 0;
    while (int'(drop_count_o) != base + 5 && waited < 100) begin
      next_cycle();
      waited++;
    end
    run_cycles(4);
    check_val("drop_count_o", 64'(drop_count_o), 64'(base + 5));
    check_val("rx words without credit", 64'(got_data_q.size() - rx_taken), 64'd0);
    end_test(5, "receive drops", e0);
  endtask

  task automatic test_code_err();
    int e0;
    int base;
    e0 = errors;
    wait_tx_drained(50);
    base      = int'(err_count_o);
    corrupt_k = 1'b1;
    next_cycle();
    corrupt_k = 1'b0;
    run_cycles(3);
    check_val("err_count_o", 64'(err_count_o), 64'(base + 1));
    end_test(6, "code error", e0);
  endtask

  initial begin
    void'($urandom(29));
    rst_n_i         = 1'b0;
    tx_valid_i      = 1'b0;
    tx_data_i       = '0;
    tx_last_i       = 1'b0;
    rx_credit_i     = 1'b0;
    mgt_codevalid_i = '1;
    mgt_syncok_i    = '0;
    mgt_rxlock_i    = '0;
    corrupt_k       = 1'b0;
    repeat (2) @(posedge mgt_clk);
    #1;
    rst_n_i = 1'b1;
    test_reset();
    test_link();
    test_frame();
    test_tx_credit();
    test_drop();
    test_code_err();
    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/xaui_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module xaui_link_top (
  input  logic                   rst_n_i,
  input  logic                   mgt_clk,
  // user transmit
  input  logic                   tx_valid_i,
  input  xaui_pkg::mgt_data_t    tx_data_i,
  input  logic                   tx_last_i,
  output logic                   tx_credit_o,
  // user receive
  input  logic                   rx_credit_i,
  output logic                   rx_valid_o,
  output xaui_pkg::mgt_data_t    rx_data_o,
  output logic                   rx_last_o,
  output logic                   link_up_o,
  // transceiver side
  output xaui_pkg::mgt_data_t    mgt_txdata_o,
  output xaui_pkg::mgt_charisk_t mgt_txcharisk_o,
  input  xaui_pkg::mgt_data_t    mgt_rxdata_i,
  input  xaui_pkg::mgt_charisk_t mgt_rxcharisk_i,
  input  xaui_pkg::mgt_charisk_t mgt_codevalid_i,
  input  xaui_pkg::lane_mask_t   mgt_syncok_i,
  input  xaui_pkg::lane_mask_t   mgt_rxlock_i,
  output logic                   mgt_tx_reset_o,
  output logic                   mgt_rx_reset_o,
  output logic                   mgt_enable_align_o,
  // status
  output link_pkg::count_t       err_count_o,
  output link_pkg::count_t       drop_count_o
);

  logic code_err;
  logic rx_word;
  logic rx_accept;

  word_stream_if ws ();

  link_ctrl link_ctrl_inst (
    .rst_n_i           (rst_n_i),
    .mgt_clk           (mgt_clk),
    .mgt_syncok_i      (mgt_syncok_i),
    .mgt_rxlock_i      (mgt_rxlock_i),
    .code_err_i        (code_err),
    .rx_word_i         (rx_word),
    .rx_credit_i       (rx_credit_i),
    .link_up_o         (link_up_o),
    .rx_accept_o       (rx_accept),
    .mgt_tx_reset_o    (mgt_tx_reset_o),
    .mgt_rx_reset_o    (mgt_rx_reset_o),
    .mgt_enable_align_o(mgt_enable_align_o),
    .err_count_o       (err_count_o),
    .drop_count_o      (drop_count_o)
  );

  tx_credit_buffer tx_credit_buffer_inst (
    .rst_n_i    (rst_n_i),
    .mgt_clk    (mgt_clk),
    .tx_valid_i (tx_valid_i),
    .tx_data_i  (tx_data_i),
    .tx_last_i  (tx_last_i),
    .tx_credit_o(tx_credit_o),
    .ws         (ws.buffer)
  );

  lane_encoder lane_encoder_inst (
    .rst_n_i        (rst_n_i),
    .mgt_clk        (mgt_clk),
    .link_up_i      (link_up_o),
    .ws             (ws.encoder),
    .mgt_txdata_o   (mgt_txdata_o),
    .mgt_txcharisk_o(mgt_txcharisk_o)
  );

  lane_decoder lane_decoder_inst (
    .rst_n_i        (rst_n_i),
    .mgt_clk        (mgt_clk),
    .link_up_i      (link_up_o),
    .mgt_rxdata_i   (mgt_rxdata_i),
    .mgt_rxcharisk_i(mgt_rxcharisk_i),
    .mgt_codevalid_i(mgt_codevalid_i),
    .rx_accept_i    (rx_accept),
    .rx_word_o      (rx_word),
    .code_err_o     (code_err),
    .rx_valid_o     (rx_valid_o),
    .rx_data_o      (rx_data_o),
    .rx_last_o      (rx_last_o)
  );

endmodule

`default_nettype wire

// File: source/lane_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module lane_decoder (
  input  logic                   rst_n_i,
  input  logic                   mgt_clk,
  input  logic                   link_up_i,
  input  xaui_pkg::mgt_data_t    mgt_rxdata_i,
  input  xaui_pkg::mgt_charisk_t mgt_rxcharisk_i,
  input  xaui_pkg::mgt_charisk_t mgt_codevalid_i,
  input  logic                   rx_accept_i,
  output logic                   rx_word_o,
  output logic                   code_err_o,
  output logic                   rx_valid_o,
  output xaui_pkg::mgt_data_t    rx_data_o,
  output logic                   rx_last_o
);

  logic all_valid;
  logic raw_idle;
  logic raw_term;
  logic raw_data;
  logic is_data;
  logic is_term;
  logic release_word;

  logic                hold_valid_q;
  xaui_pkg::mgt_data_t hold_data_q;

  // classify the received word
  assign all_valid = &mgt_codevalid_i;
  assign raw_idle  = all_valid && (mgt_rxcharisk_i == xaui_pkg::K_ALL) &&
                     (mgt_rxdata_i == xaui_pkg::IDLE_WORD);
  assign raw_term  = all_valid && (mgt_rxcharisk_i == xaui_pkg::K_ALL) &&
                     (mgt_rxdata_i == xaui_pkg::TERM_WORD);
  assign raw_data  = all_valid && (mgt_rxcharisk_i == xaui_pkg::K_NONE);

  // nothing counts while the link is down
  assign is_data    = link_up_i && raw_data;
  assign is_term    = link_up_i && raw_term;
  assign code_err_o = link_up_i && !(raw_idle || raw_term || raw_data);

  // held word leaves when the next data or terminate word shows up
  assign release_word = hold_valid_q && (is_data || is_term);
  assign rx_word_o    = release_word;

  always_ff @(posedge mgt_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_valid_q <= 1'b0;
      rx_valid_o   <= 1'b0;
    end else begin
      rx_valid_o <= release_word && rx_accept_i;
      if (!link_up_i) begin
        hold_valid_q <= 1'b0;
      end else if (is_data) begin
        hold_valid_q <= 1'b1;
      end else if (is_term) begin
        hold_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (is_data) begin
      hold_data_q <= mgt_rxdata_i;
    end
    if (release_word) begin
      rx_data_o <= hold_data_q;
      rx_last_o <= is_term; // frame ends here
    end
  end

  // far-end encoder only sends terminate straight after a data word
  term_after_data: assert property (
    @(posedge mgt_clk) disable iff (!rst_n_i)
    raw_term |-> !$past(raw_idle)
  );

endmodule

`default_nettype wire

// File: source/lane_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module lane_encoder (
  input  logic                   rst_n_i,
  input  logic                   mgt_clk,
  input  logic                   link_up_i,
  word_stream_if.encoder         ws,
  output xaui_pkg::mgt_data_t    mgt_txdata_o,
  output xaui_pkg::mgt_charisk_t mgt_txcharisk_o
);

  logic term_owed_q;

  // hold off one cycle after a last so the terminate fits in
  assign ws.take = link_up_i && !term_owed_q;

  always_ff @(posedge mgt_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      term_owed_q     <= 1'b0;
      mgt_txdata_o    <= xaui_pkg::IDLE_WORD;
      mgt_txcharisk_o <= xaui_pkg::K_ALL;
    end else if (term_owed_q) begin
      term_owed_q     <= 1'b0;
      mgt_txdata_o    <= xaui_pkg::TERM_WORD;
      mgt_txcharisk_o <= xaui_pkg::K_ALL;
    end else if (ws.valid && ws.take) begin
      term_owed_q     <= ws.last;
      mgt_txdata_o    <= ws.data;
      mgt_txcharisk_o <= xaui_pkg::K_NONE; // plain data bytes
    end else begin
      mgt_txdata_o    <= xaui_pkg::IDLE_WORD;
      mgt_txcharisk_o <= xaui_pkg::K_ALL;
    end
  end

endmodule

`default_nettype wire

// File: source/tx_credit_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_credit_buffer (
  input  logic                rst_n_i,
  input  logic                mgt_clk,
  input  logic                tx_valid_i,
  input  xaui_pkg::mgt_data_t tx_data_i,
  input  logic                tx_last_i,
  output logic                tx_credit_o,
  word_stream_if.buffer       ws
);

  xaui_pkg::mgt_data_t         data_mem [link_pkg::TX_DEPTH];
  logic [link_pkg::TX_DEPTH-1:0] last_mem;

  link_pkg::tx_ptr_t  wr_q;
  link_pkg::tx_ptr_t  rd_q;
  link_pkg::tx_addr_t wr_addr;
  link_pkg::tx_addr_t rd_addr;
  logic               full;
  logic               push;
  logic               pop;

  assign wr_addr = wr_q[link_pkg::TX_ADDR_W-1:0];
  assign rd_addr = rd_q[link_pkg::TX_ADDR_W-1:0];

  // same address, opposite wrap bits
  assign full = (wr_q[link_pkg::TX_ADDR_W] != rd_q[link_pkg::TX_ADDR_W]) &&
                (wr_addr == rd_addr);

  assign push = tx_valid_i && !full;
  assign pop  = ws.valid && ws.take;

  assign ws.valid = (wr_q != rd_q);
  assign ws.data  = data_mem[rd_addr];
  assign ws.last  = last_mem[rd_addr];

  always_ff @(posedge mgt_clk) begin
    if (push) begin
      data_mem[wr_addr] <= tx_data_i;
      last_mem[wr_addr] <= tx_last_i;
    end
  end

  always_ff @(posedge mgt_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_q        <= '0;
      rd_q        <= '0;
      tx_credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_q <= wr_q + 1'b1;
      end
      if (pop) begin
        rd_q <= rd_q + 1'b1;
      end
      tx_credit_o <= pop; // lines up with the encoder output word
    end
  end

  // user wrote without holding a credit
  tx_no_overflow: assert property (
    @(posedge mgt_clk) disable iff (!rst_n_i)
    tx_valid_i |-> !full
  );

endmodule

`default_nettype wire

// File: source/link_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module link_ctrl (
  input  logic                 rst_n_i,
  input  logic                 mgt_clk,
  input  xaui_pkg::lane_mask_t mgt_syncok_i,
  input  xaui_pkg::lane_mask_t mgt_rxlock_i,
  input  logic                 code_err_i,
  input  logic                 rx_word_i,
  input  logic                 rx_credit_i,
  output logic                 link_up_o,
  output logic                 rx_accept_o,
  output logic                 mgt_tx_reset_o,
  output logic                 mgt_rx_reset_o,
  output logic                 mgt_enable_align_o,
  output link_pkg::count_t     err_count_o,
  output link_pkg::count_t     drop_count_o
);

  link_pkg::link_state_t state_q;
  link_pkg::timer_t      timer_q;
  link_pkg::credit_t     credit_q;
  link_pkg::count_t      err_q;
  link_pkg::count_t      drop_q;
  logic                  lanes_ok;

  function automatic link_pkg::count_t sat_inc(input link_pkg::count_t val);
    return (val == link_pkg::COUNT_MAX) ? val : val + 1'b1;
  endfunction

  assign lanes_ok = (&mgt_syncok_i) && (&mgt_rxlock_i);

  // bring-up fsm
  always_ff @(posedge mgt_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= link_pkg::LINK_RESET;
      timer_q <= '0;
    end else begin
      case (state_q)
        link_pkg::LINK_RESET: begin
          timer_q <= timer_q + 1'b1;
          if (timer_q == link_pkg::timer_t'(link_pkg::RESET_CYCLES - 1)) begin
            state_q <= link_pkg::LINK_ALIGN;
          end
        end
        link_pkg::LINK_ALIGN: begin
          if (lanes_ok) begin
            state_q <= link_pkg::LINK_UP;
          end
        end
        link_pkg::LINK_UP: begin
          if (!lanes_ok) begin
            state_q <= link_pkg::LINK_ALIGN; // lost a lane, realign
          end
        end
        default: state_q <= link_pkg::LINK_RESET;
      endcase
    end
  end

  assign link_up_o          = (state_q == link_pkg::LINK_UP);
  assign mgt_tx_reset_o     = (state_q == link_pkg::LINK_RESET);
  assign mgt_rx_reset_o     = (state_q == link_pkg::LINK_RESET);
  assign mgt_enable_align_o = (state_q == link_pkg::LINK_ALIGN);

  // released word goes out only against a held credit
  assign rx_accept_o = rx_word_i && (credit_q != '0);

  always_ff @(posedge mgt_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= '0;
      err_q    <= '0;
      drop_q   <= '0;
    end else begin
      if (rx_credit_i && !rx_accept_o) begin
        if (credit_q != link_pkg::CREDIT_MAX) begin
          credit_q <= credit_q + 1'b1;
        end
      end else if (rx_accept_o && !rx_credit_i) begin
        credit_q <= credit_q - 1'b1;
      end
      if (code_err_i) begin
        err_q <= sat_inc(err_q);
      end
      if (rx_word_i && !rx_accept_o) begin
        drop_q <= sat_inc(drop_q); // no slot granted
      end
    end
  end

  assign err_count_o  = err_q;
  assign drop_count_o = drop_q;

  // an empty balance never wraps round to a full one
  credit_no_underflow: assert property (
    @(posedge mgt_clk) disable iff (!rst_n_i)
    (credit_q == '0) |=> (credit_q <= link_pkg::credit_t'(1))
  );

endmodule

`default_nettype wire

// File: source/word_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// buffered user words from the buffer to the encoder
interface word_stream_if;

  xaui_pkg::mgt_data_t data;
  logic                last;
  logic                valid; // fifo not empty
  logic                take;

  modport buffer (
    output data,
    output last,
    output valid,
    input  take
  );

  modport encoder (
    input  data,
    input  last,
    input  valid,
    output take
  );

endinterface

`default_nettype wire

// File: source/link_pkg.sv
`default_nettype none

package link_pkg;

  typedef enum logic [1:0] {
    LINK_RESET = 2'd0,
    LINK_ALIGN = 2'd1,
    LINK_UP    = 2'd2
  } link_state_t;

  // transmit buffer
  localparam int TX_DEPTH  = 8;
  localparam int TX_ADDR_W = $clog2(TX_DEPTH);
  typedef logic [TX_ADDR_W:0]   tx_ptr_t;  // msb is the wrap bit
  typedef logic [TX_ADDR_W-1:0] tx_addr_t;

  typedef logic [3:0]  credit_t;
  typedef logic [15:0] count_t;
  typedef logic [3:0]  timer_t;

  localparam credit_t CREDIT_MAX = 4'd15;
  localparam count_t  COUNT_MAX  = '1;

  // transceiver resets held this many cycles
  localparam int RESET_CYCLES = 8;

endpackage

`default_nettype wire

// File: source/xaui_pkg.sv
`default_nettype none

package xaui_pkg;

  // four lanes, two bytes per lane on each mgt_clk
  localparam int NUM_LANES  = 4;
  localparam int LANE_BYTES = 2;
  localparam int WORD_BYTES = NUM_LANES * LANE_BYTES;

  typedef logic [WORD_BYTES*8-1:0] mgt_data_t;
  typedef logic [WORD_BYTES-1:0]   mgt_charisk_t; // one k flag per byte
  typedef logic [NUM_LANES-1:0]    lane_mask_t;

  // control characters
  localparam logic [7:0] IDLE_CHAR = 8'hBC; // K28.5
  localparam logic [7:0] TERM_CHAR = 8'hFD; // K29.7

  // whole-word patterns on the line
  localparam mgt_data_t IDLE_WORD = {WORD_BYTES{IDLE_CHAR}};
  localparam mgt_data_t TERM_WORD = {WORD_BYTES{TERM_CHAR}};

  localparam mgt_charisk_t K_ALL  = '1;
  localparam mgt_charisk_t K_NONE = '0;

endpackage

`default_nettype wire
